//--- verilog/fifo_addr_defines.svh
//====================
// sizing constants for the FIFO start-address generator
// include wherever lane counts or address widths are needed
//====================

`ifndef FIFO_ADDR_DEFINES_SVH
`define FIFO_ADDR_DEFINES_SVH

// lanes per FIFO bank (ifmap, ipsum and opsum each)
`define FA_NUM_LANES    32

// global buffer byte address width
`define FA_ADDR_W       32

// depthwise channels mapped onto the lanes at once
`define FA_DW_CHANNELS  10

// rows per depthwise channel, one lane each
`define FA_DW_TAPS      3

// zero-filled region read by padding rows
`define FA_ZERO_ZONE    32'h8000_0000

`endif

//--- verilog/fifo_addr_pkg.sv
//====================
// types shared by the FIFO start-address generator
// import into any module that handles addresses or lane operations
//====================

`include "fifo_addr_defines.svh"

package fifo_addr_pkg;

    // one global buffer byte address
    typedef logic [`FA_ADDR_W-1:0] addr_t;

    // layer type from the tile scheduler
    // standard and linear carry no address logic here
    typedef enum logic [1:0] {
        LAYER_POINTWISE = 2'd0,
        LAYER_DEPTHWISE = 2'd1,
        LAYER_STANDARD  = 2'd2,
        LAYER_LINEAR    = 2'd3
    } layer_e;

    // operation applied by every lane in one init cycle
    typedef enum logic [2:0] {
        OP_HOLD        = 3'd0,
        OP_PW_LOAD     = 3'd1,
        OP_DW_PAD_LOAD = 3'd2,
        OP_DW_LOAD     = 3'd3,
        OP_DW_SHIFT    = 3'd4
    } lane_op_e;

endpackage

//--- verilog/addr_step_decode.sv
//====================
// decodes layer, tile position and output row into one lane operation
// also forms the address steps shared by all lanes, purely combinational
//====================

module addr_step_decode (
    input  logic                      init_i,
    input  fifo_addr_pkg::layer_e     layer_type_i,
    input  logic                      tile_first_i,
    input  fifo_addr_pkg::addr_t      output_row_cnt_i,
    input  fifo_addr_pkg::addr_t      tile_n_i,
    input  logic [7:0]                in_c_i,
    input  fifo_addr_pkg::addr_t      on_real_i,
    input  logic [7:0]                out_c_i,
    output fifo_addr_pkg::lane_op_e   lane_op_o,
    output fifo_addr_pkg::addr_t      ifmap_chan_step_o,
    output fifo_addr_pkg::addr_t      row_pitch_o,
    output fifo_addr_pkg::addr_t      next_row_off_o,
    output fifo_addr_pkg::addr_t      psum_pitch_o,
    output fifo_addr_pkg::addr_t      psum_row_off_o
);

    import fifo_addr_pkg::*;

    addr_t in_c_ext;
    addr_t out_c_ext;
    addr_t on_out;
    logic  row_is_zero;
    logic  row_is_one;

    assign in_c_ext  = addr_t'(in_c_i);
    assign out_c_ext = addr_t'(out_c_i);

    // bytes of one output row across all output channels, before the x2
    assign on_out = on_real_i * out_c_ext;

    assign row_is_zero = (output_row_cnt_i == addr_t'(0));
    assign row_is_one  = (output_row_cnt_i == addr_t'(1));

    // lane operation is decoded only while init is high
    always_comb begin
        lane_op_o = OP_HOLD;
        if (init_i) begin
            case (layer_type_i)
                LAYER_POINTWISE: begin
                    lane_op_o = OP_PW_LOAD;
                end
                LAYER_DEPTHWISE: begin
                    if (tile_first_i) begin
                        // first tile starts with a padding row above row 0
                        if (row_is_zero) begin
                            lane_op_o = OP_DW_PAD_LOAD;
                        end else if (row_is_one) begin
                            lane_op_o = OP_DW_LOAD;
                        end else begin
                            lane_op_o = OP_DW_SHIFT;
                        end
                    end else if (row_is_zero) begin
                        lane_op_o = OP_DW_LOAD;
                    end else begin
                        lane_op_o = OP_DW_SHIFT;
                    end
                end
                default: begin
                    lane_op_o = OP_HOLD;
                end
            endcase
        end
    end

    // row pitch is one ifmap row of in_c bytes
    assign row_pitch_o    = in_c_ext;
    assign next_row_off_o = (output_row_cnt_i + addr_t'(1)) * in_c_ext;

    // psum entries are 2 bytes wide
    always_comb begin
        if (layer_type_i == LAYER_DEPTHWISE) begin
            ifmap_chan_step_o = tile_n_i * in_c_ext;
            psum_pitch_o      = on_out << 1;
            psum_row_off_o    = (output_row_cnt_i * on_out) << 1;
        end else begin
            ifmap_chan_step_o = tile_n_i;
            psum_pitch_o      = on_real_i << 1;
            psum_row_off_o    = '0;
        end
    end

endmodule

//--- verilog/fifo_addr_lane.sv
//====================
// one FIFO lane with its ifmap, ipsum and opsum start-address registers
// LANE_IDX fixes the channel, the tap and the depthwise participation
// updates one cycle after a non-hold lane operation
//====================

`include "fifo_addr_defines.svh"

module fifo_addr_lane #(
    parameter int LANE_IDX = 0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fifo_addr_pkg::lane_op_e   lane_op_i,
    input  fifo_addr_pkg::addr_t      ifmap_base_i,
    input  fifo_addr_pkg::addr_t      ipsum_base_i,
    input  fifo_addr_pkg::addr_t      opsum_base_i,
    input  fifo_addr_pkg::addr_t      ifmap_chan_step_i,
    input  fifo_addr_pkg::addr_t      row_pitch_i,
    input  fifo_addr_pkg::addr_t      next_row_off_i,
    input  fifo_addr_pkg::addr_t      psum_pitch_i,
    input  fifo_addr_pkg::addr_t      psum_row_off_i,
    input  fifo_addr_pkg::addr_t      ifmap_next_i,
    output fifo_addr_pkg::addr_t      ifmap_addr_o,
    output fifo_addr_pkg::addr_t      ipsum_addr_o,
    output fifo_addr_pkg::addr_t      opsum_addr_o
);

    import fifo_addr_pkg::*;

    // depthwise channel and row tap served by this lane
    localparam int  CHAN     = LANE_IDX / `FA_DW_TAPS;
    localparam int  TAP      = LANE_IDX % `FA_DW_TAPS;
    localparam int  PAD_TAP  = (TAP > 0) ? TAP - 1 : 0;
    localparam bit  DW_IFMAP = (LANE_IDX < `FA_DW_CHANNELS * `FA_DW_TAPS);
    localparam bit  DW_PSUM  = (LANE_IDX < `FA_DW_CHANNELS);

    addr_t ifmap_q;
    addr_t ipsum_q;
    addr_t opsum_q;
    addr_t ifmap_d;
    addr_t ipsum_d;
    addr_t opsum_d;
    addr_t chan_base;
    addr_t psum_off;

    // start of this lane's channel in the ifmap
    assign chan_base = ifmap_base_i + addr_t'(CHAN) * ifmap_chan_step_i;

    // row offset is zero in pointwise, so both layers share this sum
    assign psum_off = psum_row_off_i + addr_t'(LANE_IDX) * psum_pitch_i;

    always_comb begin
        ifmap_d = ifmap_q;
        ipsum_d = ipsum_q;
        opsum_d = opsum_q;
        case (lane_op_i)
            OP_PW_LOAD: begin
                ifmap_d = ifmap_base_i + addr_t'(LANE_IDX) * ifmap_chan_step_i;
                ipsum_d = ipsum_base_i + psum_off;
                opsum_d = opsum_base_i + psum_off;
            end
            OP_DW_PAD_LOAD: begin
                // tap 0 reads the padding row
                if (DW_IFMAP) begin
                    if (TAP == 0) begin
                        ifmap_d = `FA_ZERO_ZONE;
                    end else begin
                        ifmap_d = chan_base + addr_t'(PAD_TAP) * row_pitch_i;
                    end
                end
            end
            OP_DW_LOAD: begin
                if (DW_IFMAP) begin
                    ifmap_d = chan_base + addr_t'(TAP) * row_pitch_i;
                end
            end
            OP_DW_SHIFT: begin
                // window slides down one row, last tap fetches the new row
                if (DW_IFMAP) begin
                    if (TAP < `FA_DW_TAPS - 1) begin
                        ifmap_d = ifmap_next_i;
                    end else begin
                        ifmap_d = chan_base + next_row_off_i;
                    end
                end
            end
            default: begin
                ifmap_d = ifmap_q;
            end
        endcase
        // every depthwise operation refreshes the psum lanes
        if (DW_PSUM && (lane_op_i == OP_DW_PAD_LOAD || lane_op_i == OP_DW_LOAD
                        || lane_op_i == OP_DW_SHIFT)) begin
            ipsum_d = ipsum_base_i + psum_off;
            opsum_d = opsum_base_i + psum_off;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifmap_q <= '0;
            ipsum_q <= '0;
            opsum_q <= '0;
        end else begin
            ifmap_q <= ifmap_d;
            ipsum_q <= ipsum_d;
            opsum_q <= opsum_d;
        end
    end

    assign ifmap_addr_o = ifmap_q;
    assign ipsum_addr_o = ipsum_q;
    assign opsum_addr_o = opsum_q;

endmodule

//--- verilog/fifo_addr_init.sv
//====================
// FIFO start-address generator for the CNN accelerator PE array
// pulse init_i for one cycle per tile row, addresses update on the next edge
// fifo_reset_o follows init_i and resets all ifmap, ipsum and opsum FIFOs
//====================

`include "fifo_addr_defines.svh"

module fifo_addr_init (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      init_i,
    input  fifo_addr_pkg::layer_e     layer_type_i,
    input  logic                      tile_first_i,
    input  fifo_addr_pkg::addr_t      output_row_cnt_i,
    input  fifo_addr_pkg::addr_t      tile_n_i,
    input  logic [7:0]                in_c_i,
    input  fifo_addr_pkg::addr_t      on_real_i,
    input  logic [7:0]                out_c_i,
    input  fifo_addr_pkg::addr_t      ifmap_base_i,
    input  fifo_addr_pkg::addr_t      ipsum_base_i,
    input  fifo_addr_pkg::addr_t      opsum_base_i,
    output fifo_addr_pkg::addr_t      ifmap_addr_o [`FA_NUM_LANES],
    output fifo_addr_pkg::addr_t      ipsum_addr_o [`FA_NUM_LANES],
    output fifo_addr_pkg::addr_t      opsum_addr_o [`FA_NUM_LANES],
    output logic                      fifo_reset_o
);

    import fifo_addr_pkg::*;

    lane_op_e lane_op;
    addr_t    ifmap_chan_step;
    addr_t    row_pitch;
    addr_t    next_row_off;
    addr_t    psum_pitch;
    addr_t    psum_row_off;

    // FIFOs stay in reset for as long as init is active
    assign fifo_reset_o = init_i;

    addr_step_decode u_decode (
        .init_i            (init_i),
        .layer_type_i      (layer_type_i),
        .tile_first_i      (tile_first_i),
        .output_row_cnt_i  (output_row_cnt_i),
        .tile_n_i          (tile_n_i),
        .in_c_i            (in_c_i),
        .on_real_i         (on_real_i),
        .out_c_i           (out_c_i),
        .lane_op_o         (lane_op),
        .ifmap_chan_step_o (ifmap_chan_step),
        .row_pitch_o       (row_pitch),
        .next_row_off_o    (next_row_off),
        .psum_pitch_o      (psum_pitch),
        .psum_row_off_o    (psum_row_off)
    );

    for (genvar g = 0; g < `FA_NUM_LANES; g++) begin : gen_lane
        // the last lane is its own shift neighbour
        localparam int NEXT = (g == `FA_NUM_LANES - 1) ? g : g + 1;

        fifo_addr_lane #(
            .LANE_IDX (g)
        ) u_lane (
            .clk               (clk),
            .rst_n             (rst_n),
            .lane_op_i         (lane_op),
            .ifmap_base_i      (ifmap_base_i),
            .ipsum_base_i      (ipsum_base_i),
            .opsum_base_i      (opsum_base_i),
            .ifmap_chan_step_i (ifmap_chan_step),
            .row_pitch_i       (row_pitch),
            .next_row_off_i    (next_row_off),
            .psum_pitch_i      (psum_pitch),
            .psum_row_off_i    (psum_row_off),
            .ifmap_next_i      (ifmap_addr_o[NEXT]),
            .ifmap_addr_o      (ifmap_addr_o[g]),
            .ipsum_addr_o      (ipsum_addr_o[g]),
            .opsum_addr_o      (opsum_addr_o[g])
        );
    end

endmodule

//--- bench/fifo_addr_assert.sv
//====================
// assertions bound into the FIFO start-address generator
// reset levels, the FIFO reset strobe and address hold
//====================

`include "fifo_addr_defines.svh"

module fifo_addr_assert (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  init_i,
    input fifo_addr_pkg::layer_e layer_type_i,
    input logic                  fifo_reset_i,
    input fifo_addr_pkg::addr_t  ifmap_addr_i [`FA_NUM_LANES],
    input fifo_addr_pkg::addr_t  ipsum_addr_i [`FA_NUM_LANES],
    input fifo_addr_pkg::addr_t  opsum_addr_i [`FA_NUM_LANES]
);

    import fifo_addr_pkg::*;

    localparam int W      = `FA_ADDR_W;
    localparam int FLAT_W = 3 * `FA_NUM_LANES * W;

    logic [FLAT_W-1:0] addr_flat;
    logic              all_zero;
    int                assert_fail_cnt = 0;

    // all three banks packed into one vector
    always_comb begin
        for (int k = 0; k < `FA_NUM_LANES; k++) begin
            addr_flat[(3*k)*W +: W]   = ifmap_addr_i[k];
            addr_flat[(3*k+1)*W +: W] = ipsum_addr_i[k];
            addr_flat[(3*k+2)*W +: W] = opsum_addr_i[k];
        end
        all_zero = (addr_flat == '0);
    end

    reset_zero_a: assert property (@(posedge clk) !rst_n |-> all_zero)
        else begin
            $error("address register not zero while reset is held");
            assert_fail_cnt++;
        end

    reset_follow_a: assert property (@(posedge clk) fifo_reset_i == init_i)
        else begin
            $error("FIFO reset does not follow init");
            assert_fail_cnt++;
        end

    // no update without init, nor for standard and linear layers
    hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (!init_i || layer_type_i == LAYER_STANDARD || layer_type_i == LAYER_LINEAR)
        |=> $stable(addr_flat))
        else begin
            $error("addresses changed on a hold cycle");
            assert_fail_cnt++;
        end

endmodule

//--- bench/fifo_addr_tb.sv
//====================
// testbench for the FIFO start-address generator
// replays records from the stim file, one init pulse per record,
// then compares the listed lanes one cycle later
//====================

`include "fifo_addr_defines.svh"

module fifo_addr_tb;

    import fifo_addr_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam STIM_FILE = "bench/fifo_addr_stim.txt";

    logic       clk;
    logic       rst_n;
    logic       init;
    layer_e     layer_type;
    logic       tile_first;
    addr_t      row_cnt;
    addr_t      tile_n;
    logic [7:0] in_c;
    addr_t      on_real;
    logic [7:0] out_c;
    addr_t      ifmap_base;
    addr_t      ipsum_base;
    addr_t      opsum_base;
    addr_t      ifmap_addr [`FA_NUM_LANES];
    addr_t      ipsum_addr [`FA_NUM_LANES];
    addr_t      opsum_addr [`FA_NUM_LANES];
    logic       fifo_reset;

    // fields of the record being replayed
    string      test_name;
    addr_t      rec_init;
    addr_t      rec_layer;
    addr_t      rec_first;
    addr_t      rec_row;
    addr_t      rec_tile_n;
    addr_t      rec_in_c;
    addr_t      rec_on_real;
    addr_t      rec_out_c;
    addr_t      rec_ifmap_base;
    addr_t      rec_ipsum_base;
    addr_t      rec_opsum_base;

    int         cycle_cnt;
    int         timeout_limit;
    int         lane_checks;

    fifo_addr_init dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .init_i           (init),
        .layer_type_i     (layer_type),
        .tile_first_i     (tile_first),
        .output_row_cnt_i (row_cnt),
        .tile_n_i         (tile_n),
        .in_c_i           (in_c),
        .on_real_i        (on_real),
        .out_c_i          (out_c),
        .ifmap_base_i     (ifmap_base),
        .ipsum_base_i     (ipsum_base),
        .opsum_base_i     (opsum_base),
        .ifmap_addr_o     (ifmap_addr),
        .ipsum_addr_o     (ipsum_addr),
        .opsum_addr_o     (opsum_addr),
        .fifo_reset_o     (fifo_reset)
    );

    bind fifo_addr_init fifo_addr_assert u_assert (
        .clk          (clk),
        .rst_n        (rst_n),
        .init_i       (init_i),
        .layer_type_i (layer_type_i),
        .fifo_reset_i (fifo_reset_o),
        .ifmap_addr_i (ifmap_addr_o),
        .ipsum_addr_i (ipsum_addr_o),
        .opsum_addr_i (opsum_addr_o)
    );

    always #20 clk = ~clk;

    // run limit scales with the number of records
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("run timed out after %0d cycles without finishing", cycle_cnt);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clk) begin
        if (dut_i.u_assert.assert_fail_cnt != 0) begin
            $display("a bound assertion failed at cycle %0d", cycle_cnt);
            $display("** FAIL **");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check_addr(input string label, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, label, exp, act);
            $display("** FAIL **");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_bit(input string label, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %b, actual %b", test_name, label, exp, act);
            $display("** FAIL **");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic compare_lane(input int lane, input addr_t e_if, input addr_t e_ip,
                                input addr_t e_op);
        if (lane < 0 || lane >= `FA_NUM_LANES) begin
            $display("record %s names lane %0d, which does not exist", test_name, lane);
            $display("** FAIL **");
            $fatal(1, "bad lane index");
        end
        check_addr($sformatf("ifmap[%0d]", lane), e_if, ifmap_addr[lane]);
        check_addr($sformatf("ipsum[%0d]", lane), e_ip, ipsum_addr[lane]);
        check_addr($sformatf("opsum[%0d]", lane), e_op, opsum_addr[lane]);
        lane_checks++;
    endtask

    // every register clears and the FIFO reset stays low
    task automatic verify_reset_state();
        for (int k = 0; k < `FA_NUM_LANES; k++) begin
            compare_lane(k, '0, '0, '0);
        end
        check_bit("fifo_reset", 1'b0, fifo_reset);
    endtask

    // idle gap, one init cycle, then sample after the update edge
    task automatic apply_record();
        int gap;
        gap = $urandom % 4;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        init       <= rec_init[0];
        layer_type <= layer_e'(rec_layer[1:0]);
        tile_first <= rec_first[0];
        row_cnt    <= rec_row;
        tile_n     <= rec_tile_n;
        in_c       <= rec_in_c[7:0];
        on_real    <= rec_on_real;
        out_c      <= rec_out_c[7:0];
        ifmap_base <= rec_ifmap_base;
        ipsum_base <= rec_ipsum_base;
        opsum_base <= rec_opsum_base;
        @(negedge clk);
        check_bit("fifo_reset", rec_init[0], fifo_reset);
        @(posedge clk);
        init <= 1'b0;
        @(negedge clk);
        check_bit("fifo_reset", 1'b0, fifo_reset);
    endtask

    function automatic int count_records(input int fd);
        string line;
        int    n;
        n = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(0) == "T") begin
                n++;
            end
        end
        return n;
    endfunction

    initial begin
        int    fd;
        int    n_fields;
        int    lane;
        string line;
        addr_t e_if;
        addr_t e_ip;
        addr_t e_op;

        clk        = 1'b0;
        rst_n      = 1'b0;
        init       = 1'b0;
        layer_type = LAYER_POINTWISE;
        tile_first = 1'b0;
        row_cnt    = '0;
        tile_n     = '0;
        in_c       = '0;
        on_real    = '0;
        out_c      = '0;
        ifmap_base = '0;
        ipsum_base = '0;
        opsum_base = '0;
        cycle_cnt     = 0;
        timeout_limit = 0;
        lane_checks   = 0;
        test_name     = "reset";
        void'($urandom(32'h1994));

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            $display("** FAIL **");
            $fatal(1, "no stimulus");
        end
        timeout_limit = count_records(fd) * 8 + 100;
        $fclose(fd);

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        verify_reset_state();

        fd = $fopen(STIM_FILE, "r");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(0) == "T") begin
                n_fields = $sscanf(line, "T %s %h %h %h %h %h %h %h %h %h %h %h", test_name,
                                   rec_init, rec_layer, rec_first, rec_row, rec_tile_n,
                                   rec_in_c, rec_on_real, rec_out_c, rec_ifmap_base,
                                   rec_ipsum_base, rec_opsum_base);
                if (n_fields != 12) begin
                    $display("malformed record line in stimulus file: %s", line);
                    $display("** FAIL **");
                    $fatal(1, "bad record");
                end
                apply_record();
            end else if (line.len() > 0 && line.getc(0) == "L") begin
                n_fields = $sscanf(line, "L %h %h %h %h", lane, e_if, e_ip, e_op);
                if (n_fields != 4) begin
                    $display("malformed lane line in stimulus file: %s", line);
                    $display("** FAIL **");
                    $fatal(1, "bad lane line");
                end
                compare_lane(lane, e_if, e_ip, e_op);
            end
        end
        $fclose(fd);

        // let the bound assertions see the last cycles
        repeat (2) @(negedge clk);
        if (dut_i.u_assert.assert_fail_cnt == 0) begin
            $display("%0d lane checks done", lane_checks);
            $display("** PASS **");
            $finish;
        end else begin
            $display("%0d assertion failures", dut_i.u_assert.assert_fail_cnt);
            $display("** FAIL **");
            $fatal(1, "assertion failures");
        end
    end

endmodule

//--- bench/fifo_addr_stim.txt
# T name init layer first row tile_n in_c on_real out_c ifmap_base ipsum_base opsum_base
# L lane ifmap ipsum opsum   (hex, expected after the record's init cycle)
T pw_load 1 0 0 0 10 8 4 2 1000 2000 3000
L 0 1000 2000 3000
L 1 1010 2008 3008
L 2 1020 2010 3010
L f 10f0 2078 3078
L 1e 11e0 20f0 30f0
L 1f 11f0 20f8 30f8
T dw_first_row0 1 1 1 0 4 10 2 3 4000 5000 6000
L 0 80000000 5000 6000
L 1 4000 500c 600c
L 2 4010 5018 6018
L 4 4040 5030 6030
L 9 80000000 506c 606c
L a 40c0 2050 3050
L 1d 4250 20e8 30e8
L 1e 11e0 20f0 30f0
L 1f 11f0 20f8 30f8
T dw_first_row1 1 1 1 1 4 10 2 3 4000 5000 6000
L 0 4000 500c 600c
L 1 4010 5018 6018
L 2 4020 5024 6024
L 3 4040 5030 6030
L 5 4060 5048 6048
L 9 40c0 5078 6078
L 1d 4260 20e8 30e8
L 1e 11e0 20f0 30f0
T dw_first_row2 1 1 1 2 4 10 2 3 4000 5000 6000
L 0 4010 5018 6018
L 1 4020 5024 6024
L 2 4030 5030 6030
L 3 4050 503c 603c
L 4 4060 5048 6048
L 5 4070 5054 6054
L 9 40d0 5084 6084
L 1b 4250 20d8 30d8
L 1c 4260 20e0 30e0
L 1d 4270 20e8 30e8
T hold_no_init 0 0 0 0 20 8 4 2 7000 7100 7200
L 0 4010 5018 6018
L 2 4030 5030 6030
L 1d 4270 20e8 30e8
L 1f 11f0 20f8 30f8
T hold_standard 1 2 1 1 20 8 4 2 7000 7100 7200
L 0 4010 5018 6018
L 1d 4270 20e8 30e8
T dw_mid_row0 1 1 0 0 2 20 1 4 8000 9000 a000
L 0 8000 9000 a000
L 1 8020 9008 a008
L 2 8040 9010 a010
L 3 8040 9018 a018
L 5 8080 9028 a028
L 9 80c0 9048 a048
L a 80e0 2050 3050
L 1d 8280 20e8 30e8
T dw_mid_row1 1 1 0 1 2 20 1 4 8000 9000 a000
L 0 8020 9008 a008
L 1 8040 9010 a010
L 2 8040 9018 a018
L 3 8060 9020 a020
L 4 8080 9028 a028
L 5 8080 9030 a030
L 9 80e0 9050 a050
L 1b 8260 20d8 30d8
L 1c 8280 20e0 30e0
L 1d 8280 20e8 30e8

//--- vlog.f
+incdir+verilog
verilog/fifo_addr_pkg.sv
verilog/addr_step_decode.sv
verilog/fifo_addr_lane.sv
verilog/fifo_addr_init.sv
bench/fifo_addr_assert.sv
bench/fifo_addr_tb.sv
